/* logic/ins_pkg.sv */
// ================================================
// Shared widths, opcodes and enums for the
// instruction stream front end.
// Opcode values are local to this front end and
// must match the decoder that follows it.
// ================================================

package ins_pkg;

	// ================================================
	// Widths that carry a meaning
	// ================================================

	// Full instruction word, opcode sits in bits 6..0
	typedef logic [31:0] ins_word_t;

	// Instruction address
	typedef logic [15:0] pc_t;

	// Interrupt priority, level 0 means no interrupt
	typedef logic [2:0] irq_level_t;

	// Interrupt vector number
	typedef logic [7:0] vector_t;

	typedef logic [6:0] opcode_t;

	// ================================================
	// Opcodes handled by the front end
	// ================================================

	// Synthetic interrupt check built from the pending interrupt
	localparam opcode_t OP_CHK = 7'h1F;
	// Micro-code call, bits 8..7 hold the micro-op count minus one
	localparam opcode_t OP_MCALL = 7'h5B;
	// One micro-op of an expanded call, bits 8..7 hold its index
	localparam opcode_t OP_MOP = 7'h5C;
	// Filler slot, always presented with out_valid low
	localparam opcode_t OP_NOP = 7'h0B;

	// ================================================
	// Enums
	// ================================================

	// Source of the word registered by the output stage
	typedef enum logic [1:0] {
		SRC_NOP,
		SRC_FETCH,
		SRC_IRQ,
		SRC_MCODE
	} src_t;

	// Control state, ST_MCODE while a call is being expanded
	typedef enum logic {
		ST_RUN,
		ST_MCODE
	} ctrl_state_t;

endpackage

/* logic/ins_extract_mux.sv */
// ================================================
// Registered output stage of the front end.
// One cycle of latency for every source.
// Micro-ops keep the pc already on the output,
// which is the pc of the no-op issued for the call.
// ================================================

`timescale 1ns/1ps

module ins_extract_mux import ins_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  src_t       sel,
	input  ins_word_t  fetch_ins,
	input  pc_t        fetch_pc,
	input  ins_word_t  mc_ins,
	input  pc_t        chk_pc,
	input  irq_level_t irq_pend_level,
	input  vector_t    irq_pend_vector,
	output logic       out_valid,
	output ins_word_t  out_ins,
	output pc_t        out_pc,
	output src_t       out_src
);

	ins_word_t nop_ins;
	ins_word_t chk_ins;

	// The no-op reuses the fetched word and only replaces the opcode
	always_comb begin
		nop_ins = fetch_ins;
		nop_ins[6:0] = OP_NOP;
	end

	// Check instruction, level in 9..7 and vector in 17..10
	// Every bit above the vector stays zero
	always_comb begin
		chk_ins = '0;
		chk_ins[6:0] = OP_CHK;
		chk_ins[9:7] = irq_pend_level;
		chk_ins[17:10] = irq_pend_vector;
	end

	// ================================================
	// Output register
	// ================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			// Come out of reset presenting an invalid no-op
			out_valid <= 1'b0;
			out_src <= SRC_NOP;
			out_ins <= nop_ins;
			out_pc <= fetch_pc;
		end else begin
			out_src <= sel;
			case (sel)
				SRC_FETCH: begin
					out_valid <= 1'b1;
					out_ins <= fetch_ins;
					out_pc <= fetch_pc;
				end
				SRC_IRQ: begin
					out_valid <= 1'b1;
					out_ins <= chk_ins;
					out_pc <= chk_pc;
				end
				SRC_MCODE: begin
					// Hold the call pc left behind by the preceding no-op
					out_valid <= 1'b1;
					out_ins <= mc_ins;
				end
				default: begin
					out_valid <= 1'b0;
					out_ins <= nop_ins;
					out_pc <= fetch_pc;
				end
			endcase
		end
	end

endmodule

/* logic/irq_pending.sv */
// ================================================
// Single entry holding the best pending interrupt.
// Lower or equal levels are dropped, not queued.
// irq_mask is sampled only when a request arrives.
// ================================================

`timescale 1ns/1ps

module irq_pending import ins_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       irq_req,
	input  irq_level_t irq_level,
	input  vector_t    irq_vector,
	input  irq_level_t irq_mask,
	input  logic       irq_take,
	output logic       irq_pend,
	output irq_level_t irq_pend_level,
	output vector_t    irq_pend_vector
);

	logic above_mask;
	logic accept;

	// Level 0 can never pass the mask, so it is never latched
	assign above_mask = irq_req && (irq_level > irq_mask);

	// A new request must also beat whatever is already waiting
	assign accept = above_mask && (!irq_pend || (irq_level > irq_pend_level));

	always_ff @(posedge clk) begin
		if (rst) begin
			irq_pend <= 1'b0;
		end else if (irq_take) begin
			// The taken entry is gone, so only the mask decides here
			irq_pend <= above_mask;
		end else if (accept) begin
			irq_pend <= 1'b1;
		end
	end

	// Level and vector carry no reset, they are qualified by irq_pend
	always_ff @(posedge clk) begin
		if ((irq_take && above_mask) || accept) begin
			irq_pend_level <= irq_level;
			irq_pend_vector <= irq_vector;
		end
	end

endmodule

/* logic/mcode_seq.sv */
// ================================================
// Expands one micro-code call into micro-ops.
// The count in bits 8..7 must already be limited
// to MAX_MOPS - 1 by the caller.
// A start while a sequence runs restarts it.
// ================================================

`timescale 1ns/1ps

module mcode_seq import ins_pkg::*; #(
	parameter int MAX_MOPS = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      mc_start,
	input  ins_word_t mc_word,
	output logic      mc_valid,
	output ins_word_t mc_ins,
	output logic      mc_last
);

	// Enough index bits to address every table entry
	localparam int IDX_W = $clog2(MAX_MOPS);

	ins_word_t  call_word;
	logic [1:0] mop_idx;
	ins_word_t  mop_tab [MAX_MOPS];

	// ================================================
	// Micro-op table
	// ================================================

	// Entry k is the call word with opcode OP_MOP and index k in 8..7
	always_comb begin
		for (int k = 0; k < MAX_MOPS; k++) begin
			mop_tab[k] = call_word;
			mop_tab[k][8:7] = 2'(k);
			mop_tab[k][6:0] = OP_MOP;
		end
	end

	assign mc_ins = mop_tab[mop_idx[IDX_W-1:0]];

	// The count field of the stored call is the index of the last entry
	assign mc_last = mc_valid && (mop_idx == call_word[8:7]);

	// ================================================
	// Sequencer
	// ================================================

	// Call word is payload, valid only while mc_valid is high
	always_ff @(posedge clk) begin
		if (mc_start) begin
			call_word <= mc_word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mc_valid <= 1'b0;
			mop_idx <= 2'd0;
		end else if (mc_start) begin
			mc_valid <= 1'b1;
			mop_idx <= 2'd0;
		end else if (mc_valid) begin
			if (mc_last) begin
				// Sequence done, go idle after this micro-op
				mc_valid <= 1'b0;
				mop_idx <= 2'd0;
			end else begin
				mop_idx <= mop_idx + 2'd1;
			end
		end
	end

endmodule

/* logic/ins_stream_ctrl.sv */
// ================================================
// Source selection for the front end.
// Fetch strobes are ignored while fetch_busy is
// high, there is no back-pressure toward fetch.
// Call counts above MAX_MOPS are clamped.
// ================================================

`timescale 1ns/1ps

module ins_stream_ctrl import ins_pkg::*; #(
	parameter int MAX_MOPS = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      fetch_valid,
	input  ins_word_t fetch_ins,
	input  pc_t       fetch_pc,
	input  logic      irq_pend,
	input  logic      mc_valid,
	input  logic      mc_last,
	output src_t      sel,
	output logic      irq_take,
	output logic      mc_start,
	output ins_word_t mc_word,
	output pc_t       chk_pc,
	output logic      fetch_busy
);

	// Highest count-minus-one the sequencer table can hold
	localparam logic [1:0] CNT_MAX = 2'(MAX_MOPS - 1);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	pc_t         resume_pc;
	logic        is_mcall;
	logic        fetch_take;

	assign is_mcall = (fetch_ins[6:0] == OP_MCALL);

	// Call word forwarded to the sequencer with its count clamped
	always_comb begin
		mc_word = fetch_ins;
		if (fetch_ins[8:7] > CNT_MAX) begin
			mc_word[8:7] = CNT_MAX;
		end
	end

	// A dropped fetch lends its pc to the check, else resume there
	assign chk_pc = fetch_valid ? fetch_pc : resume_pc;

	assign fetch_busy = (state == ST_MCODE);

	// ================================================
	// Priority and next state
	// ================================================

	always_comb begin
		sel = SRC_NOP;
		irq_take = 1'b0;
		mc_start = 1'b0;
		fetch_take = 1'b0;
		state_nxt = state;
		case (state)
			ST_RUN: begin
				if (irq_pend) begin
					// Interrupt wins, any fetch this cycle is lost
					sel = SRC_IRQ;
					irq_take = 1'b1;
				end else if (fetch_valid) begin
					fetch_take = 1'b1;
					if (is_mcall) begin
						// The call itself leaves a no-op in its slot
						mc_start = 1'b1;
						state_nxt = ST_MCODE;
					end else begin
						sel = SRC_FETCH;
					end
				end
			end
			ST_MCODE: begin
				// Interrupts and fetches wait until the last micro-op
				if (mc_valid) begin
					sel = SRC_MCODE;
				end
				if (!mc_valid || mc_last) begin
					state_nxt = ST_RUN;
				end
			end
			default: begin
				state_nxt = ST_RUN;
			end
		endcase
	end

	// ================================================
	// State and resume address
	// ================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_RUN;
			resume_pc <= '0;
		end else begin
			state <= state_nxt;
			// A call counts as an output fetch, its micro-ops follow
			if (fetch_take) begin
				resume_pc <= fetch_pc + 16'd4;
			end
		end
	end

endmodule

/* logic/ins_front.sv */
// ================================================
// Instruction stream front end, top level.
// Fetch, interrupt and no-op have one cycle of
// latency, and the output is never stalled.
// ================================================

`timescale 1ns/1ps

module ins_front import ins_pkg::*; #(
	parameter int MAX_MOPS = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       fetch_valid,
	input  ins_word_t  fetch_ins,
	input  pc_t        fetch_pc,
	input  logic       irq_req,
	input  irq_level_t irq_level,
	input  vector_t    irq_vector,
	input  irq_level_t irq_mask,
	output logic       out_valid,
	output ins_word_t  out_ins,
	output pc_t        out_pc,
	output src_t       out_src,
	output logic       fetch_busy
);

	// Pending interrupt toward control and output stage
	logic       irq_pend;
	irq_level_t irq_pend_level;
	vector_t    irq_pend_vector;
	logic       irq_take;

	// Micro-code sequencer handshake
	logic      mc_start;
	ins_word_t mc_word;
	logic      mc_valid;
	ins_word_t mc_ins;
	logic      mc_last;

	// Selection toward the output register
	src_t sel;
	pc_t  chk_pc;

	ins_stream_ctrl #(
		.MAX_MOPS(MAX_MOPS)
	) u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_ins  (fetch_ins),
		.fetch_pc   (fetch_pc),
		.irq_pend   (irq_pend),
		.mc_valid   (mc_valid),
		.mc_last    (mc_last),
		.sel        (sel),
		.irq_take   (irq_take),
		.mc_start   (mc_start),
		.mc_word    (mc_word),
		.chk_pc     (chk_pc),
		.fetch_busy (fetch_busy)
	);

	irq_pending u_irq (
		.clk            (clk),
		.rst            (rst),
		.irq_req        (irq_req),
		.irq_level      (irq_level),
		.irq_vector     (irq_vector),
		.irq_mask       (irq_mask),
		.irq_take       (irq_take),
		.irq_pend       (irq_pend),
		.irq_pend_level (irq_pend_level),
		.irq_pend_vector(irq_pend_vector)
	);

	mcode_seq #(
		.MAX_MOPS(MAX_MOPS)
	) u_mcode (
		.clk     (clk),
		.rst     (rst),
		.mc_start(mc_start),
		.mc_word (mc_word),
		.mc_valid(mc_valid),
		.mc_ins  (mc_ins),
		.mc_last (mc_last)
	);

	ins_extract_mux u_mux (
		.clk            (clk),
		.rst            (rst),
		.sel            (sel),
		.fetch_ins      (fetch_ins),
		.fetch_pc       (fetch_pc),
		.mc_ins         (mc_ins),
		.chk_pc         (chk_pc),
		.irq_pend_level (irq_pend_level),
		.irq_pend_vector(irq_pend_vector),
		.out_valid      (out_valid),
		.out_ins        (out_ins),
		.out_pc         (out_pc),
		.out_src        (out_src)
	);

endmodule

/* verification/ins_front_tb.sv */
// ==================================================
// Self-checking testbench for the front end.
// The testbench plays fetch and the interrupt source.
// A model steps on the rising edge, and the outputs
// are compared on the falling edge.
// ==================================================

`timescale 1ns/1ps

module ins_front_tb import ins_pkg::*; ();

	localparam int MAX_MOPS = 4;
	localparam int N_RAND = 400;
	localparam int DIRECTED_CYCLES = 80;
	// Reset, directed and random cycles plus a margin, at 8 ns each
	localparam int WATCHDOG_NS = (5 + DIRECTED_CYCLES + N_RAND + 50) * 8;

	logic       clk;
	logic       rst;
	logic       fetch_valid;
	ins_word_t  fetch_ins;
	pc_t        fetch_pc;
	logic       irq_req;
	irq_level_t irq_level;
	vector_t    irq_vector;
	irq_level_t irq_mask;
	logic       out_valid;
	ins_word_t  out_ins;
	pc_t        out_pc;
	src_t       out_src;
	logic       fetch_busy;

	// Model of the sequence, the pending interrupt and the resume address
	logic       m_busy;
	ins_word_t  m_call;
	pc_t        m_call_pc;
	logic [1:0] m_idx;
	logic       m_pend;
	irq_level_t m_plevel;
	vector_t    m_pvec;
	pc_t        m_resume;
	src_t       m_src;
	logic       m_take;
	logic       m_start;
	logic       m_above;
	logic       m_accept;
	logic [48:0] m_pred;

	// Expected outputs for the cycle after the last rising edge
	logic      exp_valid;
	ins_word_t exp_ins;
	pc_t       exp_pc;
	src_t      exp_src;
	logic      exp_busy;
	logic      chk_en = 1'b0;

	int n_checks = 0;
	int n_err = 0;
	int n_misc = 0;
	logic [31:0] rnd;

	ins_front #(
		.MAX_MOPS(MAX_MOPS)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_ins  (fetch_ins),
		.fetch_pc   (fetch_pc),
		.irq_req    (irq_req),
		.irq_level  (irq_level),
		.irq_vector (irq_vector),
		.irq_mask   (irq_mask),
		.out_valid  (out_valid),
		.out_ins    (out_ins),
		.out_pc     (out_pc),
		.out_src    (out_src),
		.fetch_busy (fetch_busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// ==================================================
	// Reference model
	// ==================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1103515245 + 32'd12345;
	endfunction

	// Encodes the output word for a source as {valid, ins, pc}
	function automatic logic [48:0] predict_output(input src_t src, input ins_word_t f_ins,
		input pc_t f_pc, input ins_word_t call, input logic [1:0] idx, input irq_level_t lvl,
		input vector_t vec, input pc_t chk_pc, input pc_t call_pc);
		logic      v;
		ins_word_t ins;
		pc_t       pc;
		case (src)
			SRC_FETCH: begin
				v = 1'b1;
				ins = f_ins;
				pc = f_pc;
			end
			SRC_IRQ: begin
				v = 1'b1;
				ins = {14'd0, vec, lvl, OP_CHK};
				pc = chk_pc;
			end
			SRC_MCODE: begin
				// Micro-op k carries k in 8..7 and the pc of its call
				v = 1'b1;
				ins = {call[31:9], idx, OP_MOP};
				pc = call_pc;
			end
			default: begin
				v = 1'b0;
				ins = {f_ins[31:7], OP_NOP};
				pc = f_pc;
			end
		endcase
		return {v, ins, pc};
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			m_busy = 1'b0;
			m_idx = 2'd0;
			m_pend = 1'b0;
			m_resume = '0;
			m_src = SRC_NOP;
			m_pred = predict_output(SRC_NOP, fetch_ins, fetch_pc, m_call, m_idx, m_plevel,
				m_pvec, m_resume, m_call_pc);
			exp_busy = 1'b0;
		end else begin
			m_take = 1'b0;
			m_start = 1'b0;
			// Priority: micro-op, interrupt, fetch, no-op
			if (m_busy) begin
				m_src = SRC_MCODE;
			end else if (m_pend) begin
				m_src = SRC_IRQ;
				m_take = 1'b1;
			end else if (fetch_valid && fetch_ins[6:0] == OP_MCALL) begin
				m_src = SRC_NOP;
				m_start = 1'b1;
			end else if (fetch_valid) begin
				m_src = SRC_FETCH;
			end else begin
				m_src = SRC_NOP;
			end
			m_pred = predict_output(m_src, fetch_ins, fetch_pc, m_call, m_idx, m_plevel,
				m_pvec, fetch_valid ? fetch_pc : m_resume, m_call_pc);
			if (!m_busy && !m_pend && fetch_valid) begin
				m_resume = fetch_pc + 16'd4;
			end
			if (m_busy) begin
				if (m_idx == m_call[8:7]) begin
					m_busy = 1'b0;
					m_idx = 2'd0;
				end else begin
					m_idx = m_idx + 2'd1;
				end
			end else if (m_start) begin
				m_busy = 1'b1;
				m_idx = 2'd0;
				m_call = fetch_ins;
				m_call_pc = fetch_pc;
			end
			// A request in the take cycle only has to pass the mask
			m_above = irq_req && (irq_level > irq_mask);
			m_accept = m_above && (m_take || !m_pend || irq_level > m_plevel);
			if (m_accept) begin
				m_plevel = irq_level;
				m_pvec = irq_vector;
			end
			if (m_take) begin
				m_pend = m_above;
			end else if (m_accept) begin
				m_pend = 1'b1;
			end
			exp_busy = m_busy;
		end
		exp_valid = m_pred[48];
		exp_ins = m_pred[47:16];
		exp_pc = m_pred[15:0];
		exp_src = m_src;
		chk_en = 1'b1;
	end

	// ==================================================
	// Comparator
	// ==================================================

	always @(negedge clk) begin
		if (chk_en) begin
			n_checks = n_checks + 1;
			assert (out_valid === exp_valid) else begin
				n_err = n_err + 1;
				$display("[FAIL] %0t: out_valid %b, expected %b", $time, out_valid, exp_valid);
			end
			assert (out_src === exp_src) else begin
				n_err = n_err + 1;
				$display("[FAIL] %0t: out_src %0d, expected %0d", $time, out_src, exp_src);
			end
			assert (out_ins === exp_ins) else begin
				n_err = n_err + 1;
				$display("[FAIL] %0t: out_ins %h, expected %h", $time, out_ins, exp_ins);
			end
			assert (out_pc === exp_pc) else begin
				n_err = n_err + 1;
				$display("[FAIL] %0t: out_pc %h, expected %h", $time, out_pc, exp_pc);
			end
			assert (fetch_busy === exp_busy) else begin
				n_err = n_err + 1;
				$display("[FAIL] %0t: fetch_busy %b, expected %b", $time, fetch_busy, exp_busy);
			end
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic drive_cycle(input logic fv, input ins_word_t ins, input pc_t pc,
		input logic req, input irq_level_t lvl, input vector_t vec);
		@(posedge clk);
		fetch_valid <= fv;
		fetch_ins <= ins;
		fetch_pc <= pc;
		irq_req <= req;
		irq_level <= lvl;
		irq_vector <= vec;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b0, 3'd0, 8'h00);
		end
	endtask

	// Idles until the sequence ends and reads fetch_busy on the falling edge
	task automatic drain_mcode();
		int waited;
		waited = 0;
		do begin
			idle_cycles(1);
			@(negedge clk);
			waited++;
		end while (fetch_busy && waited < 16);
		if (fetch_busy) begin
			n_misc++;
			$display("fetch_busy stayed high for 16 cycles, the micro-code sequence never ended");
		end
	endtask

	initial begin
		logic [31:0] word;
		logic        fv;
		logic        req;
		rnd = 32'd30;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_ins = '0;
		fetch_pc = '0;
		irq_req = 1'b0;
		irq_level = '0;
		irq_vector = '0;
		irq_mask = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idle_cycles(3);
		@(negedge clk);
		assert (!out_valid && !fetch_busy && out_src == SRC_NOP) else begin
			n_misc++;
			$display("[FAIL] %0t: outputs are not an idle no-op after reset", $time);
		end
		// Plain fetch, then a three and a four micro-op call
		drive_cycle(1'b1, 32'h1234_5633, 16'h0100, 1'b0, 3'd0, 8'h00);
		idle_cycles(2);
		drive_cycle(1'b1, {23'h05A5A5, 2'd2, OP_MCALL}, 16'h0104, 1'b0, 3'd0, 8'h00);
		drain_mcode();
		drive_cycle(1'b1, {23'h7F0F0F, 2'd3, OP_MCALL}, 16'h0200, 1'b0, 3'd0, 8'h00);
		drain_mcode();
		idle_cycles(1);
		irq_mask <= 3'd2;
		// Interrupt taken together with a fetch, which is dropped
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd5, 8'h42);
		drive_cycle(1'b1, 32'hDEAD_BE33, 16'h0300, 1'b0, 3'd0, 8'h00);
		idle_cycles(2);
		// Masked levels, then one that resumes at the saved address
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd1, 8'h11);
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd2, 8'h22);
		idle_cycles(2);
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd3, 8'h33);
		idle_cycles(3);
		// Interrupts during a call wait for the last micro-op
		drive_cycle(1'b1, {23'h123456, 2'd3, OP_MCALL}, 16'h0400, 1'b0, 3'd0, 8'h00);
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd6, 8'h66);
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd4, 8'h44);
		drive_cycle(1'b0, 32'h0000_0013, 16'h0000, 1'b1, 3'd7, 8'h77);
		drain_mcode();
		idle_cycles(3);
		// Mixed random run
		for (int i = 0; i < N_RAND; i++) begin
			rnd = lcg_next(rnd);
			word = rnd;
			rnd = lcg_next(rnd);
			@(negedge clk);
			fv = !fetch_busy && (rnd[31:29] < 3'd5);
			if (rnd[28:26] == 3'd0) begin
				word[6:0] = OP_MCALL;
			end
			req = (rnd[25:23] == 3'd0);
			drive_cycle(fv, word, {rnd[15:2], 2'b00}, req, rnd[22:20], rnd[19:12]);
			if (rnd[11:8] == 4'd0) begin
				irq_mask <= {1'b0, rnd[7:6]};
			end
		end
		drain_mcode();
		idle_cycles(3);
		@(negedge clk);
		$display("Checks: %0d, value errors: %0d, other errors: %0d", n_checks, n_err, n_misc);
		if (n_err == 0 && n_misc == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the run did not end within %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

/* flist.f */
logic/ins_pkg.sv
logic/ins_extract_mux.sv
logic/irq_pending.sv
logic/mcode_seq.sv
logic/ins_stream_ctrl.sv
logic/ins_front.sv
verification/ins_front_tb.sv

/* run.sh */
#!/bin/sh
# Builds the front-end testbench with Verilator, runs it and judges the log.
# A build or run error also writes the fail message into the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert -j 0 --top-module ins_front_tb \
	-Mdir obj_dir -o ins_front_sim -f flist.f \
	&& ./obj_dir/ins_front_sim \
	|| echo "test failed"; } 2>&1 | tee sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
